//--- all.f
source/fpu_ss_pkg.sv
source/fpu_ss_decoder.sv
source/fpu_ss_regfile.sv
source/fpu_ss_controller.sv
source/fpu_ss_exec.sv
source/fpu_ss.sv
testbench/fpu_ss_checker.sv
testbench/tb_fpu_ss.sv

//--- run.sh
#!/bin/bash
# Compile with Verilator, run the testbench, then search the log for a failure
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/10ps -f all.f --top-module tb_fpu_ss \
  -Mdir obj_dir -o tb_fpu_ss > build.log 2>&1 &&
./obj_dir/tb_fpu_ss > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- source/fpu_ss.sv
/*
  Top level of the FP offload subsystem. Connects issue, decode, register
  file, scoreboard and pipeline, and drives the result interface.
*/
`timescale 1ns/10ps

module fpu_ss
  import fpu_ss_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,

  // Issue interface
  input  logic        issue_valid_i,
  input  issue_req_t  issue_req_i,
  output logic        issue_ready_o,
  output issue_resp_t issue_resp_o,

  // Result interface
  output logic        result_valid_o,
  output result_t     result_o,
  input  logic        result_ready_i
);

  decoded_t        dec;
  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  exec_in_t        exec_in;
  logic            exec_valid;
  logic            exec_ready;
  logic            result_xfer;
  logic            result_is_fp;

  fpu_ss_decoder u_decoder (
    .instr_i (issue_req_i.instr),
    .dec_o   (dec)
  );

  assign issue_resp_o.accept    = dec.valid_op;
  assign issue_resp_o.writeback = dec.valid_op & ~dec.rd_is_fp;

  // --------------------------------------------------------------------------
  // Operand fetch
  // --------------------------------------------------------------------------
  fpu_ss_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (result_xfer & result_is_fp),
    .waddr_i   (result_o.rd),
    .wdata_i   (result_o.data)
  );

  // FMV.W.X takes its operand from the integer side
  assign exec_in.op       = dec.op;
  assign exec_in.a        = dec.rs1_is_fp ? rdata_a : issue_req_i.rs1;
  assign exec_in.b        = rdata_b;
  assign exec_in.rd       = dec.rd;
  assign exec_in.rd_is_fp = dec.rd_is_fp;
  assign exec_in.id       = issue_req_i.id;

  fpu_ss_controller u_controller (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .dec_i         (dec),
    .issue_ready_o (issue_ready_o),
    .exec_valid_o  (exec_valid),
    .exec_ready_i  (exec_ready),
    .wb_valid_i    (result_xfer),
    .wb_addr_i     (result_o.rd),
    .wb_is_fp_i    (result_is_fp)
  );

  fpu_ss_exec u_exec (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (exec_valid),
    .in_ready_o  (exec_ready),
    .in_i        (exec_in),
    .out_valid_o (result_valid_o),
    .out_ready_i (result_ready_i),
    .out_o       (result_o),
    .out_is_fp_o (result_is_fp)
  );

  assign result_xfer = result_valid_o & result_ready_i;

endmodule

//--- source/fpu_ss_controller.sv
/*
  Issue control. Tracks pending FP register writes in a scoreboard and holds
  issue back on a hazard or when the pipeline is full.
*/
`timescale 1ns/10ps

module fpu_ss_controller
  import fpu_ss_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,

  // Issue side
  input  logic                  issue_valid_i,
  input  decoded_t              dec_i,
  output logic                  issue_ready_o,

  // Pipeline input handshake
  output logic                  exec_valid_o,
  input  logic                  exec_ready_i,

  // Result transfer
  input  logic                  wb_valid_i,
  input  logic [REG_ADDR_W-1:0] wb_addr_i,
  input  logic                  wb_is_fp_i
);

  logic [NUM_REGS-1:0] sb_q;
  logic                hazard_rs1;
  logic                hazard_rs2;
  logic                hazard_rd;
  logic                hazard;
  logic                issue_fp_write;

  // --------------------------------------------------------------------------
  // Hazard detection
  // --------------------------------------------------------------------------
  assign hazard_rs1 = dec_i.rs1_is_fp & sb_q[dec_i.rs1];
  assign hazard_rs2 = dec_i.rs2_used  & sb_q[dec_i.rs2];
  // WAW, keeps one pending write per register
  assign hazard_rd  = dec_i.rd_is_fp  & sb_q[dec_i.rd];
  assign hazard     = dec_i.valid_op & (hazard_rs1 | hazard_rs2 | hazard_rd);

  assign issue_ready_o = exec_ready_i & ~hazard;
  assign exec_valid_o  = issue_valid_i & dec_i.valid_op & ~hazard;

  assign issue_fp_write = exec_valid_o & exec_ready_i & dec_i.rd_is_fp;

  // --------------------------------------------------------------------------
  // Scoreboard
  // --------------------------------------------------------------------------
  // Set and clear never hit the same entry, a set needs the bit clear
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sb_q <= '0;
    end else begin
      if (wb_valid_i && wb_is_fp_i) begin
        sb_q[wb_addr_i] <= 1'b0;
      end
      if (issue_fp_write) begin
        sb_q[dec_i.rd] <= 1'b1;
      end
    end
  end

endmodule

//--- source/fpu_ss_decoder.sv
/*
  Decodes one offloaded instruction word. Combinational, it feeds both the
  issue response and the operand fetch.
*/
`timescale 1ns/10ps

module fpu_ss_decoder
  import fpu_ss_pkg::*;
(
  input  logic [XLEN-1:0] instr_i,
  output decoded_t        dec_o
);

  localparam logic [6:0] OPC_OP_FP   = 7'b1010011;
  localparam logic [6:0] F7_FMV_W_X  = 7'b1111000;
  localparam logic [6:0] F7_FMV_X_W  = 7'b1110000;
  localparam logic [6:0] F7_FSGNJ    = 7'b0010000;
  localparam logic [6:0] F7_FCMP     = 7'b1010000;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic       rs2_zero;

  assign opcode   = instr_i[6:0];
  assign funct7   = instr_i[31:25];
  assign funct3   = instr_i[14:12];
  assign rs2_zero = (instr_i[24:20] == '0);

  always_comb begin
    dec_o           = '0;
    dec_o.op        = OP_NONE;
    dec_o.rs1       = instr_i[19:15];
    dec_o.rs2       = instr_i[24:20];
    dec_o.rd        = instr_i[11:7];

    if (opcode == OPC_OP_FP) begin
      case (funct7)
        F7_FMV_W_X: begin
          if (funct3 == 3'b000 && rs2_zero) begin
            dec_o.op       = OP_FMV;
            dec_o.rd_is_fp = 1'b1;
            dec_o.valid_op = 1'b1;
          end
        end
        F7_FMV_X_W: begin
          if (funct3 == 3'b000 && rs2_zero) begin
            dec_o.op        = OP_FMV;
            dec_o.rs1_is_fp = 1'b1;
            dec_o.valid_op  = 1'b1;
          end
        end
        F7_FSGNJ: begin
          dec_o.rs1_is_fp = 1'b1;
          dec_o.rs2_used  = 1'b1;
          dec_o.rd_is_fp  = 1'b1;
          case (funct3)
            3'b000:  dec_o.op = OP_FSGNJ;
            3'b001:  dec_o.op = OP_FSGNJN;
            3'b010:  dec_o.op = OP_FSGNJX;
            default: dec_o.op = OP_NONE;
          endcase
          dec_o.valid_op = (dec_o.op != OP_NONE);
        end
        F7_FCMP: begin
          // Compares write an integer register
          dec_o.rs1_is_fp = 1'b1;
          dec_o.rs2_used  = 1'b1;
          case (funct3)
            3'b010:  dec_o.op = OP_FEQ;
            3'b001:  dec_o.op = OP_FLT;
            3'b000:  dec_o.op = OP_FLE;
            default: dec_o.op = OP_NONE;
          endcase
          dec_o.valid_op = (dec_o.op != OP_NONE);
        end
        default: ;
      endcase
    end
  end

endmodule

//--- source/fpu_ss_exec.sv
/*
  Two-stage execution pipeline for moves, sign injection and compares.
  Stage one holds operands, stage two holds the result until it is taken.
*/
`timescale 1ns/10ps

module fpu_ss_exec
  import fpu_ss_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,

  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  exec_in_t in_i,

  output logic     out_valid_o,
  input  logic     out_ready_i,
  output result_t  out_o,
  output logic     out_is_fp_o
);

  exec_in_t        s1_q;
  logic            s1_valid_q;
  logic            s1_ready;
  result_t         s2_q;
  logic            s2_is_fp_q;
  logic            s2_valid_q;
  logic            s2_ready;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic            a_lt_b;
  logic            a_eq_b;
  logic [XLEN-1:0] res_d;

  // A stage takes new data when empty or when its content moves on
  assign s2_ready   = ~s2_valid_q | out_ready_i;
  assign s1_ready   = ~s1_valid_q | s2_ready;
  assign in_ready_o = s1_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= in_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stage two datapath
  // --------------------------------------------------------------------------
  assign op_a   = s1_q.a;
  assign op_b   = s1_q.b;
  assign a_eq_b = (op_a == op_b);

  // Sign-magnitude order, so -0 sorts below +0
  always_comb begin
    if (op_a[XLEN-1] != op_b[XLEN-1]) begin
      a_lt_b = op_a[XLEN-1];
    end else if (op_a[XLEN-1]) begin
      a_lt_b = (op_a[XLEN-2:0] > op_b[XLEN-2:0]);
    end else begin
      a_lt_b = (op_a[XLEN-2:0] < op_b[XLEN-2:0]);
    end
  end

  always_comb begin
    case (s1_q.op)
      OP_FMV:    res_d = op_a;
      OP_FSGNJ:  res_d = {op_b[XLEN-1], op_a[XLEN-2:0]};
      OP_FSGNJN: res_d = {~op_b[XLEN-1], op_a[XLEN-2:0]};
      OP_FSGNJX: res_d = {op_a[XLEN-1] ^ op_b[XLEN-1], op_a[XLEN-2:0]};
      OP_FEQ:    res_d = {{(XLEN-1){1'b0}}, a_eq_b};
      OP_FLT:    res_d = {{(XLEN-1){1'b0}}, a_lt_b};
      OP_FLE:    res_d = {{(XLEN-1){1'b0}}, a_lt_b | a_eq_b};
      default:   res_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && s1_ready) begin
      s1_q <= in_i;
    end
    if (s1_valid_q && s2_ready) begin
      s2_q.data  <= res_d;
      s2_q.rd    <= s1_q.rd;
      s2_q.id    <= s1_q.id;
      s2_q.we    <= ~s1_q.rd_is_fp;
      s2_is_fp_q <= s1_q.rd_is_fp;
    end
  end

  assign out_valid_o = s2_valid_q;
  assign out_o       = s2_q;
  assign out_is_fp_o = s2_is_fp_q;

endmodule

//--- source/fpu_ss_pkg.sv
/*
  Shared widths, operation codes and interface structs of the FP offload
  subsystem. Imported by every RTL module and by the testbench.
*/
package fpu_ss_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 2 ** REG_ADDR_W;
  localparam int ID_W       = 4;

  // Both FMV directions share OP_FMV, the decoded fp/int flags set the direction
  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,
    OP_FMV    = 3'd1,
    OP_FSGNJ  = 3'd2,
    OP_FSGNJN = 3'd3,
    OP_FSGNJX = 3'd4,
    OP_FEQ    = 3'd5,
    OP_FLT    = 3'd6,
    OP_FLE    = 3'd7
  } fpu_op_e;

  // --------------------------------------------------------------------------
  // Issue interface
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs1;
    logic [ID_W-1:0] id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
  } issue_resp_t;

  // Decoder output
  typedef struct packed {
    fpu_op_e               op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rs1_is_fp;
    logic                  rs2_used;
    logic                  rd_is_fp;
    logic                  valid_op;
  } decoded_t;

  // Pipeline input, operands already selected
  typedef struct packed {
    fpu_op_e               op;
    logic [XLEN-1:0]       a;
    logic [XLEN-1:0]       b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_is_fp;
    logic [ID_W-1:0]       id;
  } exec_in_t;

  // Result interface, we marks an integer register write
  typedef struct packed {
    logic [XLEN-1:0]       data;
    logic [REG_ADDR_W-1:0] rd;
    logic [ID_W-1:0]       id;
    logic                  we;
  } result_t;

endpackage

//--- source/fpu_ss_regfile.sv
/*
  Single-precision register file, 32 entries. Two asynchronous read ports,
  one synchronous write port.
*/
`timescale 1ns/10ps

module fpu_ss_regfile
  import fpu_ss_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o,
  input  logic                  we_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i
);

  logic [XLEN-1:0] regs_q [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

//--- testbench/fpu_ss_checker.sv
/*
  Result and issue monitor for the FP offload testbench. Compares each result
  transfer with the head of the expected queue and keeps the error counts.
*/
`timescale 1ns/10ps

module fpu_ss_checker
  import fpu_ss_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        issue_valid_i,
  input  logic        issue_ready_i,
  input  issue_resp_t issue_resp_i,
  input  issue_resp_t exp_resp_i,
  input  logic        exp_push_i,
  input  result_t     exp_i,
  input  logic        result_valid_i,
  input  logic        result_ready_i,
  input  result_t     result_i,
  input  logic        test_done_i,
  input  int          test_num_i,
  input  logic        report_i,
  output int          pending_o,
  output int          errors_o
);

  result_t exp_q [$];
  result_t exp;
  result_t held_q;
  logic    stall_q;
  int      checked;
  int      checked_mark;
  int      err_mark;
  int      tests;

  initial begin
    pending_o    = 0;
    errors_o     = 0;
    stall_q      = 1'b0;
    held_q       = '0;
    checked      = 0;
    checked_mark = 0;
    err_mark     = 0;
    tests        = 0;
  end

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (issue_valid_i && issue_ready_i && issue_resp_i !== exp_resp_i) begin
        $display("Mismatch at %0t: accept %0b writeback %0b, expected %0b and %0b", $time,
                 issue_resp_i.accept, issue_resp_i.writeback, exp_resp_i.accept,
                 exp_resp_i.writeback);
        errors_o++;
      end

      // A stalled result must stay valid and unchanged
      if (stall_q && (!result_valid_i || result_i !== held_q)) begin
        $display("Result dropped or changed while result_ready_i was low, at %0t", $time);
        errors_o++;
      end
      stall_q = result_valid_i && !result_ready_i;
      held_q  = result_i;

      if (result_valid_i && result_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Result with id %0d arrived with no instruction outstanding, at %0t",
                   result_i.id, $time);
          errors_o++;
        end else begin
          exp = exp_q.pop_front();
          checked++;
          if (result_i !== exp) begin
            $write("Mismatch at %0t: id %0d data %h rd %0d we %0b", $time, result_i.id,
                   result_i.data, result_i.rd, result_i.we);
            $display(", expected id %0d data %h rd %0d we %0b", exp.id, exp.data, exp.rd,
                     exp.we);
            errors_o++;
          end
        end
      end

      if (exp_push_i) begin
        exp_q.push_back(exp_i);
      end
      pending_o = exp_q.size();

      if (test_done_i) begin
        tests++;
        $display("Test %0d finished: %0d results checked, %0d errors", test_num_i,
                 checked - checked_mark, errors_o - err_mark);
        checked_mark = checked;
        err_mark     = errors_o;
      end

      if (report_i) begin
        if (exp_q.size() != 0) begin
          $display("%0d expected results never arrived", exp_q.size());
          errors_o++;
        end
        $display("Summary: %0d tests, %0d results checked, %0d errors", tests, checked,
                 errors_o);
      end
    end
  end

endmodule

//--- testbench/tb_fpu_ss.sv
/*
  Testbench for the FP offload subsystem. Issues LFSR driven instruction
  streams, predicts results from a shadow register file and ends on a report.
*/
`timescale 1ns/10ps

module tb_fpu_ss
  import fpu_ss_pkg::*;
();

  localparam int          CLK_PERIOD = 40;
  localparam logic [31:0] SEED       = 32'ha2f8_b402;
  localparam int          N_INSTR    = 16 + 32 + 32 + 24 + 40 + 8;
  localparam int          TIMEOUT_NS = (5 + 40 * N_INSTR) * CLK_PERIOD;

  // Instruction kinds of the stimulus
  localparam int K_FMV_WX = 0;
  localparam int K_FMV_XW = 1;
  localparam int K_SGNJ   = 2;
  localparam int K_SGNJN  = 3;
  localparam int K_SGNJX  = 4;
  localparam int K_FEQ    = 5;
  localparam int K_FLT    = 6;
  localparam int K_FLE    = 7;

  logic        clk;
  logic        rst;
  logic        issue_valid;
  issue_req_t  issue_req;
  logic        issue_ready;
  issue_resp_t issue_resp;
  logic        result_valid;
  result_t     result;
  logic        result_ready;

  issue_resp_t exp_resp;
  logic        exp_push;
  result_t     exp_res;
  logic        test_done;
  int          test_num;
  logic        report;
  int          pending;
  int          errors;

  logic        ready_random;
  logic [31:0] lfsr_q;
  logic [31:0] ready_lfsr_q;
  logic [3:0]  next_id;
  logic [31:0] shadow [32];

  fpu_ss u_fpu_ss (
    .clk_i          (clk),
    .rst_i          (rst),
    .issue_valid_i  (issue_valid),
    .issue_req_i    (issue_req),
    .issue_ready_o  (issue_ready),
    .issue_resp_o   (issue_resp),
    .result_valid_o (result_valid),
    .result_o       (result),
    .result_ready_i (result_ready)
  );

  fpu_ss_checker u_checker (
    .clk_i          (clk),
    .rst_i          (rst),
    .issue_valid_i  (issue_valid),
    .issue_ready_i  (issue_ready),
    .issue_resp_i   (issue_resp),
    .exp_resp_i     (exp_resp),
    .exp_push_i     (exp_push),
    .exp_i          (exp_res),
    .result_valid_i (result_valid),
    .result_ready_i (result_ready),
    .result_i       (result),
    .test_done_i    (test_done),
    .test_num_i     (test_num),
    .report_i       (report),
    .pending_o      (pending),
    .errors_o       (errors)
  );

  // --------------------------------------------------------------------------
  // Random numbers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] v;
    v = lfsr_bits(5);
    return v[4:0];
  endfunction

  // --------------------------------------------------------------------------
  // Encoding and reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] r2;
    r2 = rs2;
    f3 = 3'b000;
    case (kind)
      K_FMV_WX: begin
        f7 = 7'b1111000;
        r2 = 5'd0;
      end
      K_FMV_XW: begin
        f7 = 7'b1110000;
        r2 = 5'd0;
      end
      K_SGNJ:  f7 = 7'b0010000;
      K_SGNJN: begin
        f7 = 7'b0010000;
        f3 = 3'b001;
      end
      K_SGNJX: begin
        f7 = 7'b0010000;
        f3 = 3'b010;
      end
      K_FEQ: begin
        f7 = 7'b1010000;
        f3 = 3'b010;
      end
      K_FLT: begin
        f7 = 7'b1010000;
        f3 = 3'b001;
      end
      default: f7 = 7'b1010000;
    endcase
    return {f7, r2, rs1, f3, rd, 7'b1010011};
  endfunction

  // Maps sign-magnitude values onto integers so -0 lands just below +0
  function automatic logic signed [32:0] order_key(input logic [31:0] v);
    if (v[31]) begin
      return -$signed({2'b00, v[30:0]}) - 33'sd1;
    end
    return $signed({2'b00, v[30:0]});
  endfunction

  function automatic result_t predict_result(input int kind, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [31:0] xval, input logic [3:0] id);
    logic [31:0]        a;
    logic [31:0]        b;
    logic signed [32:0] ka;
    logic signed [32:0] kb;
    result_t            r;
    a      = shadow[rs1];
    b      = shadow[rs2];
    ka     = order_key(a);
    kb     = order_key(b);
    r.rd   = rd;
    r.id   = id;
    r.we   = (kind == K_FMV_XW) || (kind >= K_FEQ);
    case (kind)
      K_FMV_WX: r.data = xval;
      K_FMV_XW: r.data = a;
      K_SGNJ:   r.data = {b[31], a[30:0]};
      K_SGNJN:  r.data = {~b[31], a[30:0]};
      K_SGNJX:  r.data = {a[31] ^ b[31], a[30:0]};
      K_FEQ:    r.data = (ka == kb) ? 32'd1 : 32'd0;
      K_FLT:    r.data = (ka < kb) ? 32'd1 : 32'd0;
      default:  r.data = (ka <= kb) ? 32'd1 : 32'd0;
    endcase
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Issue helpers
  // --------------------------------------------------------------------------
  // Holds the request until a transfer and samples ready at the falling edge
  task automatic send(input logic [31:0] instr, input logic [31:0] xval,
                      input logic acc, input result_t exp);
    logic done;
    done               = 1'b0;
    issue_valid        = 1'b1;
    issue_req.instr    = instr;
    issue_req.rs1      = xval;
    issue_req.id       = next_id;
    exp_resp.accept    = acc;
    exp_resp.writeback = acc & exp.we;
    while (!done) begin
      @(negedge clk);
      if (issue_ready) begin
        done     = 1'b1;
        exp_push = acc;
        exp_res  = exp;
      end
      @(posedge clk);
      #2;
    end
    issue_valid = 1'b0;
    exp_push    = 1'b0;
    next_id     = next_id + 4'd1;
  endtask

  task automatic run_op(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2, input logic [31:0] xval);
    result_t exp;
    exp = predict_result(kind, rd, rs1, rs2, xval, next_id);
    if (!exp.we) begin
      shadow[rd] = exp.data;
    end
    send(encode(kind, rd, rs1, rs2), xval, 1'b1, exp);
  endtask

  task automatic finish_test(input int num);
    while (pending != 0) begin
      @(posedge clk);
      #2;
    end
    test_num  = num;
    test_done = 1'b1;
    @(posedge clk);
    #2;
    test_done = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic move_round_trip();
    logic [4:0] fr;
    for (int i = 0; i < 8; i++) begin
      fr = rand_reg();
      run_op(K_FMV_WX, fr, rand_reg(), 5'd0, lfsr_bits(32));
      run_op(K_FMV_XW, rand_reg(), fr, 5'd0, 32'd0);
    end
  endtask

  task automatic sign_injection();
    logic [31:0] k;
    for (int i = 0; i < 8; i++) begin
      run_op(K_FMV_WX, rand_reg(), rand_reg(), 5'd0, lfsr_bits(32));
    end
    for (int i = 0; i < 24; i++) begin
      k = lfsr_bits(2);
      run_op(K_SGNJ + (k[1:0] == 2'd3 ? 0 : {30'd0, k[1:0]}), rand_reg(), rand_reg(),
             rand_reg(), 32'd0);
    end
  endtask

  task automatic compare_order();
    logic [31:0] v;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] k;
    v = lfsr_bits(32);
    run_op(K_FMV_WX, 5'd1, 5'd0, 5'd0, 32'h0000_0000);
    run_op(K_FMV_WX, 5'd2, 5'd0, 5'd0, 32'h8000_0000);
    run_op(K_FMV_WX, 5'd3, 5'd0, 5'd0, v);
    run_op(K_FMV_WX, 5'd4, 5'd0, 5'd0, v);
    run_op(K_FMV_WX, 5'd5, 5'd0, 5'd0, v ^ 32'h8000_0000);
    for (int i = 6; i < 9; i++) begin
      run_op(K_FMV_WX, i[4:0], 5'd0, 5'd0, lfsr_bits(32));
    end
    run_op(K_FEQ, rand_reg(), 5'd1, 5'd2, 32'd0);
    run_op(K_FLT, rand_reg(), 5'd2, 5'd1, 32'd0);
    run_op(K_FLE, rand_reg(), 5'd3, 5'd4, 32'd0);
    run_op(K_FEQ, rand_reg(), 5'd3, 5'd4, 32'd0);
    for (int i = 0; i < 20; i++) begin
      k = lfsr_bits(2);
      a = lfsr_bits(3) + 32'd1;
      b = lfsr_bits(3) + 32'd1;
      run_op(K_FEQ + (k[1:0] == 2'd3 ? 0 : {30'd0, k[1:0]}), rand_reg(), a[4:0], b[4:0],
             32'd0);
    end
  endtask

  // Every instruction reads the destination written just before it
  task automatic dependency_chain();
    logic [4:0]  prev;
    logic [4:0]  rd;
    logic [31:0] k;
    prev = rand_reg();
    run_op(K_FMV_WX, prev, 5'd0, 5'd0, lfsr_bits(32));
    for (int i = 0; i < 23; i++) begin
      k  = lfsr_bits(2);
      rd = rand_reg();
      if (k[1:0] == 2'd3) begin
        run_op(K_FMV_XW, rd, prev, 5'd0, 32'd0);
      end else begin
        run_op(K_SGNJ + {30'd0, k[1:0]}, rd, prev, rand_reg(), 32'd0);
        prev = rd;
      end
    end
  endtask

  task automatic backpressure_stream();
    logic [31:0] k;
    ready_random = 1'b1;
    for (int i = 0; i < 40; i++) begin
      k = lfsr_bits(3);
      run_op({29'd0, k[2:0]}, rand_reg(), rand_reg(), rand_reg(), lfsr_bits(32));
    end
    while (pending != 0) begin
      @(posedge clk);
      #2;
    end
    ready_random = 1'b0;
  endtask

  task automatic reject_unsupported();
    logic [31:0] word;
    for (int i = 0; i < 8; i++) begin
      word = lfsr_bits(32);
      if (word[6:0] == 7'b1010011) begin
        word[2] = ~word[2];
      end
      send(word, lfsr_bits(32), 1'b0, '0);
    end
    // Leave room for a stray result to show up
    repeat (4) @(posedge clk);
    #2;
  endtask

  // --------------------------------------------------------------------------
  // Clock, ready driver, main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    result_ready = 1'b1;
    ready_lfsr_q = SEED;
    forever begin
      @(posedge clk);
      #2;
      if (ready_random) begin
        ready_lfsr_q = lfsr_next(ready_lfsr_q);
        result_ready = ready_lfsr_q[0];
      end else begin
        result_ready = 1'b1;
      end
    end
  end

  initial begin
    rst          = 1'b1;
    issue_valid  = 1'b0;
    issue_req    = '0;
    exp_resp     = '0;
    exp_push     = 1'b0;
    exp_res      = '0;
    test_done    = 1'b0;
    test_num     = 0;
    report       = 1'b0;
    ready_random = 1'b0;
    lfsr_q       = SEED;
    next_id      = '0;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    move_round_trip();
    finish_test(1);
    sign_injection();
    finish_test(2);
    compare_order();
    finish_test(3);
    dependency_chain();
    finish_test(4);
    backpressure_stream();
    finish_test(5);
    reject_unsupported();
    finish_test(6);

    report = 1'b1;
    @(posedge clk);
    #2;
    report = 1'b0;
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

endmodule
